// ==== logic/ks_arith_pkg.sv ====
`default_nettype none

package ks_arith_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath geometry
    ////////////////////////////////////////////////////////////////////////////

    // Operand width in bits
    localparam int WIDTH = 32;

    // Prefix positions, position 0 carries the carry-in
    localparam int POSITIONS = WIDTH + 1;

    // Kogge-Stone rows, span doubles each row
    localparam int PREFIX_ROWS = $clog2(POSITIONS);

    ////////////////////////////////////////////////////////////////////////////
    // Operations and result flags
    ////////////////////////////////////////////////////////////////////////////

    // Code 3 is illegal
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_ADC = 2'd2
    } ks_op_e;

    // Spare bit reads as zero
    typedef struct packed {
        logic spare;
        logic cout;
        logic ovf;
        logic zero;
    } ks_flags_t;

endpackage

`default_nettype wire

// ==== logic/ks_stream_pkg.sv ====
`default_nettype none

package ks_stream_pkg;

    // Tag width, enough for the two items in flight plus bench ordering checks
    localparam int TAG_W = 4;

    // Incoming request
    typedef struct packed {
        logic [ks_arith_pkg::WIDTH-1:0] a;
        logic [ks_arith_pkg::WIDTH-1:0] b;
        ks_arith_pkg::ks_op_e           op;
        logic                           cin;
        logic [TAG_W-1:0]               tag;
    } ks_req_t;

    // Stage 1 to stage 2 word
    typedef struct packed {
        logic [ks_arith_pkg::POSITIONS-1:0] p;
        logic [ks_arith_pkg::POSITIONS-1:0] g;
        logic [TAG_W-1:0]                   tag;
    } ks_pg_word_t;

    // Outgoing response
    typedef struct packed {
        logic [ks_arith_pkg::WIDTH-1:0] sum;
        ks_arith_pkg::ks_flags_t        flags;
        logic [TAG_W-1:0]               tag;
    } ks_resp_t;

endpackage

`default_nettype wire

// ==== logic/ks_pg_stage.sv ====
`default_nettype none

module ks_pg_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        valid,
    input  ks_stream_pkg::ks_req_t     req,
    output ks_stream_pkg::ks_pg_word_t word
);

    logic [ks_arith_pkg::WIDTH-1:0] b_eff;
    logic                           cin_eff;

    // Operation decode
    always_comb begin
        b_eff   = req.b;
        cin_eff = 1'b0;
        case (req.op)
            ks_arith_pkg::OP_SUB: begin
                // a + ~b + 1
                b_eff   = ~req.b;
                cin_eff = 1'b1;
            end
            ks_arith_pkg::OP_ADC: begin
                cin_eff = req.cin;
            end
            default: begin
            end
        endcase
    end

    // Bit i of the operands lands at position i+1
    // Position 0 never propagates and generates the carry-in
    assign word.p   = {req.a ^ b_eff, 1'b0};
    assign word.g   = {req.a & b_eff, cin_eff};
    assign word.tag = req.tag;

    // Only legal ops may be offered upstream
    a_legal_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> req.op inside {ks_arith_pkg::OP_ADD, ks_arith_pkg::OP_SUB,
                                 ks_arith_pkg::OP_ADC}
    );

endmodule

`default_nettype wire

// ==== logic/ks_prefix_tree.sv ====
`default_nettype none

module ks_prefix_tree (
    input  wire [ks_arith_pkg::POSITIONS-1:0] p,
    input  wire [ks_arith_pkg::POSITIONS-1:0] g,
    output wire [ks_arith_pkg::POSITIONS-1:0] carry
);

    localparam int POS  = ks_arith_pkg::POSITIONS;
    localparam int ROWS = ks_arith_pkg::PREFIX_ROWS;

    // Row 0 is the raw pg input, row ROWS is fully resolved
    logic [POS-1:0] g_row [ROWS+1];
    logic [POS-1:0] p_row [ROWS+1];

    assign g_row[0] = g;
    assign p_row[0] = p;

    ////////////////////////////////////////////////////////////////////////////
    // Kogge-Stone rows
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 1; r <= ROWS; r++) begin : g_rows
        localparam int SPAN = 1 << (r - 1);

        for (genvar i = 0; i < POS; i++) begin : g_pos
            if (i < SPAN) begin : g_copy
                // Already resolved
                assign g_row[r][i] = g_row[r-1][i];
                assign p_row[r][i] = p_row[r-1][i];
            end else if (i < 2 * SPAN) begin : g_grey
                // Partner is resolved, so only the generate is needed
                assign g_row[r][i] = g_row[r-1][i] |
                                     (p_row[r-1][i] & g_row[r-1][i-SPAN]);
                // Group now reaches position 0, which never propagates
                assign p_row[r][i] = 1'b0;
            end else begin : g_black
                assign g_row[r][i] = g_row[r-1][i] |
                                     (p_row[r-1][i] & g_row[r-1][i-SPAN]);
                assign p_row[r][i] = p_row[r-1][i] & p_row[r-1][i-SPAN];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    // Group generate over 0..i is the carry into operand bit i
    assign carry = g_row[ROWS];

endmodule

`default_nettype wire

// ==== logic/ks_sum_stage.sv ====
`default_nettype none

module ks_sum_stage (
    input  wire [ks_arith_pkg::POSITIONS-1:0]   p,
    input  wire [ks_arith_pkg::POSITIONS-1:0]   carry,
    input  wire [ks_stream_pkg::TAG_W-1:0]      tag,
    output ks_stream_pkg::ks_resp_t             resp
);

    localparam int W = ks_arith_pkg::WIDTH;

    logic [W-1:0] sum;

    // Operand bit i sits at propagate position i+1
    assign sum = p[W:1] ^ carry[W-1:0];

    assign resp.sum = sum;
    assign resp.tag = tag;

    // Carry out of the top bit
    assign resp.flags.cout = carry[W];

    // Signed overflow when carry into and out of the MSB differ
    assign resp.flags.ovf = carry[W-1] ^ carry[W];

    assign resp.flags.zero  = ~|sum;
    assign resp.flags.spare = 1'b0;

endmodule

`default_nettype wire

// ==== logic/ks_pipe_reg.sv ====
`default_nettype none

module ks_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Stalled output holds
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

    // While full and not draining nothing loads, so the refused item is still offered
    a_no_load_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && out_valid && !out_ready |=> in_valid && $stable(in_data)
    );

endmodule

`default_nettype wire

// ==== logic/ks_addsub_top.sv ====
`default_nettype none

module ks_addsub_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      in_valid,
    output wire                      in_ready,
    input  ks_stream_pkg::ks_req_t   in_req,
    output wire                      out_valid,
    input  wire                      out_ready,
    output ks_stream_pkg::ks_resp_t  out_resp
);

    ks_stream_pkg::ks_pg_word_t            pg_word;
    ks_stream_pkg::ks_pg_word_t            pg_q;
    logic                                  pg_valid;
    logic                                  pg_ready;
    logic [ks_arith_pkg::POSITIONS-1:0]    carry;
    ks_stream_pkg::ks_resp_t               resp_d;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, propagate and generate
    ////////////////////////////////////////////////////////////////////////////

    ks_pg_stage pg_stage_i (
        .clk   (clk),
        .rst_n (rst_n),
        .valid (in_valid),
        .req   (in_req),
        .word  (pg_word)
    );

    ks_pipe_reg #(.payload_t(ks_stream_pkg::ks_pg_word_t)) pipe_pg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (pg_word),
        .out_valid (pg_valid),
        .out_ready (pg_ready),
        .out_data  (pg_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, prefix tree and sum
    ////////////////////////////////////////////////////////////////////////////

    ks_prefix_tree tree_i (
        .p     (pg_q.p),
        .g     (pg_q.g),
        .carry (carry)
    );

    ks_sum_stage sum_stage_i (
        .p     (pg_q.p),
        .carry (carry),
        .tag   (pg_q.tag),
        .resp  (resp_d)
    );

    ks_pipe_reg #(.payload_t(ks_stream_pkg::ks_resp_t)) pipe_resp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pg_valid),
        .in_ready  (pg_ready),
        .in_data   (resp_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_resp)
    );

endmodule

`default_nettype wire

// ==== bench/ks_addsub_tb.sv ====
`default_nettype none

module ks_addsub_tb;

    localparam int W              = ks_arith_pkg::WIDTH;
    localparam int TW             = ks_stream_pkg::TAG_W;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int N_ADD          = 200;
    localparam int N_SUBADC       = 200;
    localparam int N_CORNER       = 6;
    localparam int N_STALL        = 300;
    localparam int N_LATENCY      = 50;
    localparam int TOTAL_REQS     = N_ADD + N_SUBADC + N_CORNER + N_STALL + N_LATENCY;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20 + RESET_CYCLES;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    ks_stream_pkg::ks_req_t  in_req;
    logic                    out_valid;
    logic                    out_ready;
    ks_stream_pkg::ks_resp_t out_resp;

    // Requests waiting to be offered, and responses still owed by the DUT
    ks_stream_pkg::ks_req_t  send_q[$];
    ks_stream_pkg::ks_resp_t exp_q[$];
    int                      acc_cycle_q[$];

    logic [31:0]   rng_state = 32'd74587;
    logic [TW-1:0] next_tag  = '0;
    int            cycle     = 0;
    int            errors    = 0;
    int            checks    = 0;
    bit            offered   = 1'b0;

    ks_addsub_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    function automatic ks_stream_pkg::ks_resp_t expected_resp(input ks_stream_pkg::ks_req_t req);
        ks_stream_pkg::ks_resp_t resp;
        logic [W:0]              full;
        logic [W-1:0]            carry_in;
        resp     = '0;
        resp.tag = req.tag;
        if (req.op == ks_arith_pkg::OP_SUB) begin
            resp.sum        = req.a - req.b;
            resp.flags.cout = req.a >= req.b;
            // Opposite signs and the result lost the sign of a
            resp.flags.ovf  = (req.a[W-1] != req.b[W-1]) && (resp.sum[W-1] != req.a[W-1]);
        end else begin
            carry_in = '0;
            if (req.op == ks_arith_pkg::OP_ADC) begin
                carry_in[0] = req.cin;
            end
            full            = {1'b0, req.a} + {1'b0, req.b} + {1'b0, carry_in};
            resp.sum        = full[W-1:0];
            resp.flags.cout = full[W];
            resp.flags.ovf  = (req.a[W-1] == req.b[W-1]) && (resp.sum[W-1] != req.a[W-1]);
        end
        resp.flags.zero = resp.sum == '0;
        return resp;
    endfunction

    task automatic queue_req(input ks_arith_pkg::ks_op_e op, input logic [W-1:0] a,
                             input logic [W-1:0] b, input logic cin);
        ks_stream_pkg::ks_req_t req;
        req.a   = a;
        req.b   = b;
        req.op  = op;
        req.cin = cin;
        req.tag = next_tag;
        next_tag = next_tag + 1'b1;
        send_q.push_back(req);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_handshake(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_sum(input logic [W-1:0] got_sum, input logic [TW-1:0] got_tag,
                             input logic [W-1:0] want_sum, input logic [TW-1:0] want_tag);
        if (got_tag !== want_tag) begin
            $display("MISMATCH at %0t: tag got %0d expected %0d", $time, got_tag, want_tag);
            errors++;
        end
        if (got_sum !== want_sum) begin
            $display("MISMATCH at %0t: sum for tag %0d got %h expected %h",
                     $time, want_tag, got_sum, want_sum);
            errors++;
        end
    endtask

    task automatic check_flags(input ks_arith_pkg::ks_flags_t got,
                               input ks_arith_pkg::ks_flags_t want);
        if (got !== want) begin
            $display("MISMATCH at %0t: flags {spare,cout,ovf,zero} got %b expected %b",
                     $time, got, want);
            errors++;
        end
    endtask

    task automatic take_response(input bit check_latency);
        ks_stream_pkg::ks_resp_t want;
        int                      acc_cycle;
        if (exp_q.size() == 0) begin
            $display("ERROR: response with tag %0d at %0t has no outstanding request",
                     out_resp.tag, $time);
            errors++;
        end else begin
            want      = exp_q.pop_front();
            acc_cycle = acc_cycle_q.pop_front();
            check_sum(out_resp.sum, out_resp.tag, want.sum, want.tag);
            check_flags(out_resp.flags, want.flags);
            if (check_latency && (cycle - acc_cycle != 2)) begin
                $display("MISMATCH at %0t: latency %0d cycles, expected 2",
                         $time, cycle - acc_cycle);
                errors++;
            end
            checks++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stream driver
    ////////////////////////////////////////////////////////////////////////////

    // Handshakes sampled mid-cycle, inputs changed on the rising edge
    task automatic run_stream(input int valid_pct, input int ready_pct, input bit check_latency);
        logic [31:0] r;
        bit          in_acc;
        bit          out_acc;
        while (send_q.size() != 0 || exp_q.size() != 0 || offered) begin
            @(negedge clk);
            in_acc  = in_valid && in_ready;
            out_acc = out_valid && out_ready;
            if (out_acc) begin
                take_response(check_latency);
            end
            if (in_acc) begin
                exp_q.push_back(expected_resp(in_req));
                acc_cycle_q.push_back(cycle);
            end
            @(posedge clk);
            // A request stays offered until it is taken
            if (in_acc || !offered) begin
                next_rand(r);
                if (send_q.size() != 0 && (r % 100) < valid_pct) begin
                    in_req   <= send_q.pop_front();
                    in_valid <= 1'b1;
                    offered = 1'b1;
                end else begin
                    in_valid <= 1'b0;
                    offered = 1'b0;
                end
            end
            next_rand(r);
            out_ready <= (r % 100) < ready_pct;
        end
        // Nothing may follow the last response
        repeat (4) begin
            @(negedge clk);
            if (out_valid) begin
                $display("ERROR: extra response with tag %0d at %0t", out_resp.tag, $time);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_mark, input int chk_mark);
        $display("%-12s %0d responses checked, %0d errors", name, checks - chk_mark,
                 errors - err_mark);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          err_mark;
        int          chk_mark;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n     <= 1'b1;
        out_ready <= 1'b1;

        err_mark = errors;
        chk_mark = checks;
        @(negedge clk);
        check_handshake("out_valid after reset", out_valid, 1'b0);
        check_handshake("in_ready after reset with out_ready high", in_ready, 1'b1);
        report_test("reset", err_mark, chk_mark);

        err_mark = errors;
        chk_mark = checks;
        repeat (N_ADD) begin
            next_rand(a);
            next_rand(b);
            queue_req(ks_arith_pkg::OP_ADD, a, b, b[3]);
        end
        run_stream(70, 100, 1'b0);
        report_test("add_random", err_mark, chk_mark);

        err_mark = errors;
        chk_mark = checks;
        repeat (N_SUBADC) begin
            next_rand(a);
            next_rand(b);
            next_rand(r);
            // Equal operands now and then for the a >= b boundary
            if (r[5:2] == 4'd0) begin
                b = a;
            end
            if (r[0]) begin
                queue_req(ks_arith_pkg::OP_SUB, a, b, r[1]);
            end else begin
                queue_req(ks_arith_pkg::OP_ADC, a, b, r[1]);
            end
        end
        run_stream(80, 100, 1'b0);
        report_test("sub_adc", err_mark, chk_mark);

        err_mark = errors;
        chk_mark = checks;
        queue_req(ks_arith_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b0);
        queue_req(ks_arith_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b0);
        queue_req(ks_arith_pkg::OP_SUB, 32'h1234_5678, 32'h1234_5678, 1'b0);
        queue_req(ks_arith_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0001, 1'b0);
        queue_req(ks_arith_pkg::OP_ADC, 32'hffff_ffff, 32'h0000_0000, 1'b1);
        queue_req(ks_arith_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001, 1'b0);
        run_stream(100, 100, 1'b0);
        report_test("corners", err_mark, chk_mark);

        err_mark = errors;
        chk_mark = checks;
        repeat (N_STALL) begin
            next_rand(a);
            next_rand(b);
            next_rand(r);
            if (r % 3 == 0) begin
                queue_req(ks_arith_pkg::OP_ADD, a, b, r[8]);
            end else if (r % 3 == 1) begin
                queue_req(ks_arith_pkg::OP_SUB, a, b, r[8]);
            end else begin
                queue_req(ks_arith_pkg::OP_ADC, a, b, r[8]);
            end
        end
        run_stream(60, 50, 1'b0);
        report_test("stalls", err_mark, chk_mark);

        err_mark = errors;
        chk_mark = checks;
        repeat (N_LATENCY) begin
            next_rand(a);
            next_rand(b);
            queue_req(ks_arith_pkg::OP_ADD, a, b, 1'b0);
        end
        run_stream(100, 100, 1'b1);
        report_test("latency", err_mark, chk_mark);

        $display("Summary: %0d responses checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: run did not finish within %0d cycles, the DUT appears to hang",
                 TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ks_addsub.f ====
logic/ks_arith_pkg.sv
logic/ks_stream_pkg.sv
logic/ks_pg_stage.sv
logic/ks_prefix_tree.sv
logic/ks_sum_stage.sv
logic/ks_pipe_reg.sv
logic/ks_addsub_top.sv
bench/ks_addsub_tb.sv

// ==== Makefile ====
# Verilator build and run for the ks_addsub testbench

VERILATOR ?= verilator
TOP       ?= ks_addsub_tb
FILELIST  ?= ks_addsub.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
